//--- logic/frame_pkg.sv
`default_nettype none

package frame_pkg;

  // 4 bits each of red, green, blue
  localparam int pixel_w = 12;

  // horizontal timing in clocks
  localparam int h_active     = 16;
  localparam int h_total      = 20;
  localparam int h_sync_start = 17;
  localparam int h_sync_end   = 19;

  // vertical timing in lines
  localparam int v_active    = 8;
  localparam int v_total     = 10;
  localparam int v_sync_line = 9;

  // one bank holds exactly the visible area
  localparam int frame_pixels = h_active * v_active;
  localparam int addr_w       = $clog2(frame_pixels);

  // raster counter widths
  localparam int h_cnt_w = $clog2(h_total);
  localparam int v_cnt_w = $clog2(v_total);

  // finished back frame waiting for the raster's frame end
  typedef enum logic {
    swap_idle,
    swap_pending
  } swap_state_t;

endpackage

`default_nettype wire

//--- logic/mem_if.sv
`timescale 1ns/1ps
`default_nettype none

interface mem_if import frame_pkg::*; ();

  logic               en;
  logic               we;
  logic [ addr_w-1:0] addr;
  logic [pixel_w-1:0] wdata;
  // valid the cycle after a read request
  logic [pixel_w-1:0] rdata;

  modport requester (
    output en, we, addr, wdata,
    input  rdata
  );

  modport memory (
    input  en, we, addr, wdata,
    output rdata
  );

endinterface

`default_nettype wire

//--- logic/frame_writer.sv
`timescale 1ns/1ps
`default_nettype none

module frame_writer import frame_pkg::*; (
  input  wire               clk,
  input  wire               rst_n,
  input  wire               wr_en,
  input  wire [pixel_w-1:0] wr_pixel,
  input  wire               hold,
  output logic              frame_done,
  mem_if.requester          mem
);

  logic [addr_w-1:0] wr_addr;
  logic              accept;
  logic              last_pixel;

  // pixels offered while held are dropped
  assign accept     = wr_en && !hold;
  assign last_pixel = (wr_addr == addr_w'(frame_pixels - 1));

  // the whole frame is in once the last address is written
  assign frame_done = accept && last_pixel;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_addr <= '0;
    end else if (accept) begin
      if (last_pixel) begin
        wr_addr <= '0;
      end else begin
        wr_addr <= wr_addr + 1'b1;
      end
    end
  end

  // write only, one pixel per accepted strobe
  assign mem.en    = accept;
  assign mem.we    = 1'b1;
  assign mem.addr  = wr_addr;
  assign mem.wdata = wr_pixel;

endmodule

`default_nettype wire

//--- logic/bank_switch.sv
`timescale 1ns/1ps
`default_nettype none

module bank_switch import frame_pkg::*; (
  input  wire      clk,
  input  wire      rst_n,
  input  wire      frame_done,
  input  wire      frame_end,
  output logic     hold,
  output logic     frame_swap,
  mem_if.memory    wr_side,
  mem_if.memory    rd_side,
  mem_if.requester bank0,
  mem_if.requester bank1
);

  swap_state_t state;
  // 0: scanner reads bank0, writer fills bank1
  logic        front_sel;
  logic        front_sel_d;

  assign hold = (state == swap_pending);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state      <= swap_idle;
      front_sel  <= 1'b0;
      frame_swap <= 1'b0;
    end else begin
      frame_swap <= 1'b0;
      case (state)
        swap_idle: begin
          if (frame_done) begin
            state <= swap_pending;
          end
        end
        swap_pending: begin
          // exchange banks only between frames
          if (frame_end) begin
            state      <= swap_idle;
            front_sel  <= ~front_sel;
            frame_swap <= 1'b1;
          end
        end
        default: state <= swap_idle;
      endcase
    end
  end

  // read data comes back a cycle late, so steer it with the old select
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      front_sel_d <= 1'b0;
    end else begin
      front_sel_d <= front_sel;
    end
  end

  always_comb begin
    if (front_sel) begin
      bank1.en    = rd_side.en;
      bank1.we    = rd_side.we;
      bank1.addr  = rd_side.addr;
      bank1.wdata = rd_side.wdata;
      bank0.en    = wr_side.en;
      bank0.we    = wr_side.we;
      bank0.addr  = wr_side.addr;
      bank0.wdata = wr_side.wdata;
    end else begin
      bank0.en    = rd_side.en;
      bank0.we    = rd_side.we;
      bank0.addr  = rd_side.addr;
      bank0.wdata = rd_side.wdata;
      bank1.en    = wr_side.en;
      bank1.we    = wr_side.we;
      bank1.addr  = wr_side.addr;
      bank1.wdata = wr_side.wdata;
    end
  end

  assign rd_side.rdata = front_sel_d ? bank1.rdata : bank0.rdata;
  assign wr_side.rdata = front_sel_d ? bank0.rdata : bank1.rdata;

endmodule

`default_nettype wire

//--- logic/frame_bank.sv
`timescale 1ns/1ps
`default_nettype none

module frame_bank import frame_pkg::*; (
  input  wire   clk,
  mem_if.memory mem
);

  logic [pixel_w-1:0] store [frame_pixels];

  // single port, write has priority over read
  always_ff @(posedge clk) begin
    if (mem.en) begin
      if (mem.we) begin
        store[mem.addr] <= mem.wdata;
      end else begin
        mem.rdata <= store[mem.addr];
      end
    end
  end

endmodule

`default_nettype wire

//--- logic/raster_scan.sv
`timescale 1ns/1ps
`default_nettype none

module raster_scan import frame_pkg::*; (
  input  wire      clk,
  input  wire      rst_n,
  mem_if.requester mem,
  output logic     hsync,
  output logic     vsync,
  output logic     de,
  output logic     frame_end
);

  logic [h_cnt_w-1:0] h_cnt;
  logic [v_cnt_w-1:0] v_cnt;
  logic               line_end;
  logic               visible;

  assign line_end = (h_cnt == h_cnt_w'(h_total - 1));

  // free running, never stalls
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      h_cnt <= '0;
      v_cnt <= '0;
    end else if (line_end) begin
      h_cnt <= '0;
      if (v_cnt == v_cnt_w'(v_total - 1)) begin
        v_cnt <= '0;
      end else begin
        v_cnt <= v_cnt + 1'b1;
      end
    end else begin
      h_cnt <= h_cnt + 1'b1;
    end
  end

  assign visible = (h_cnt < h_cnt_w'(h_active)) && (v_cnt < v_cnt_w'(v_active));

  // one read per visible pixel, raster order
  assign mem.en    = visible;
  assign mem.we    = 1'b0;
  assign mem.addr  = addr_w'(v_cnt) * addr_w'(h_active) + addr_w'(h_cnt);
  assign mem.wdata = '0;

  // syncs are active low
  assign hsync = !((h_cnt >= h_cnt_w'(h_sync_start)) && (h_cnt < h_cnt_w'(h_sync_end)));
  assign vsync = !(v_cnt == v_cnt_w'(v_sync_line));
  assign de    = visible;

  // last clock of the frame, swap point
  assign frame_end = line_end && (v_cnt == v_cnt_w'(v_total - 1));

endmodule

`default_nettype wire

//--- logic/pixel_out.sv
`timescale 1ns/1ps
`default_nettype none

module pixel_out import frame_pkg::*; (
  input  wire               clk,
  input  wire               rst_n,
  input  wire [pixel_w-1:0] rdata,
  input  wire               hsync,
  input  wire               vsync,
  input  wire               de,
  output logic [3:0]        vga_red,
  output logic [3:0]        vga_green,
  output logic [3:0]        vga_blue,
  output logic              vga_hsync,
  output logic              vga_vsync,
  output logic              vga_de
);

  // first stage, matches the bank read latency
  logic hsync_d;
  logic vsync_d;
  logic de_d;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      hsync_d   <= 1'b1;
      vsync_d   <= 1'b1;
      de_d      <= 1'b0;
      vga_hsync <= 1'b1;
      vga_vsync <= 1'b1;
      vga_de    <= 1'b0;
      vga_red   <= '0;
      vga_green <= '0;
      vga_blue  <= '0;
    end else begin
      hsync_d   <= hsync;
      vsync_d   <= vsync;
      de_d      <= de;
      vga_hsync <= hsync_d;
      vga_vsync <= vsync_d;
      vga_de    <= de_d;
      // blank outside the active area
      vga_red   <= de_d ? rdata[11:8] : 4'h0;
      vga_green <= de_d ? rdata[7:4]  : 4'h0;
      vga_blue  <= de_d ? rdata[3:0]  : 4'h0;
    end
  end

endmodule

`default_nettype wire

//--- logic/frame_buffer_top.sv
`timescale 1ns/1ps
`default_nettype none

module frame_buffer_top import frame_pkg::*; (
  input  wire               clk,
  input  wire               rst_n,

  // host pixel stream
  input  wire               wr_en,
  input  wire [pixel_w-1:0] wr_pixel,
  output logic              wr_busy,
  output logic              frame_swap,

  // display
  output logic [3:0]        vga_red,
  output logic [3:0]        vga_green,
  output logic [3:0]        vga_blue,
  output logic              vga_hsync,
  output logic              vga_vsync,
  output logic              vga_de
);

  mem_if wr_bus ();
  mem_if rd_bus ();
  mem_if bank0_bus ();
  mem_if bank1_bus ();

  logic frame_done;
  logic frame_end;
  logic scan_hsync;
  logic scan_vsync;
  logic scan_de;

  frame_writer u_frame_writer (
    .clk       (clk),
    .rst_n     (rst_n),
    .wr_en     (wr_en),
    .wr_pixel  (wr_pixel),
    .hold      (wr_busy),
    .frame_done(frame_done),
    .mem       (wr_bus.requester)
  );

  // two by two router between writer/scanner and the banks
  bank_switch u_bank_switch (
    .clk       (clk),
    .rst_n     (rst_n),
    .frame_done(frame_done),
    .frame_end (frame_end),
    .hold      (wr_busy),
    .frame_swap(frame_swap),
    .wr_side   (wr_bus.memory),
    .rd_side   (rd_bus.memory),
    .bank0     (bank0_bus.requester),
    .bank1     (bank1_bus.requester)
  );

  frame_bank u_bank0 (
    .clk(clk),
    .mem(bank0_bus.memory)
  );

  frame_bank u_bank1 (
    .clk(clk),
    .mem(bank1_bus.memory)
  );

  raster_scan u_raster_scan (
    .clk      (clk),
    .rst_n    (rst_n),
    .mem      (rd_bus.requester),
    .hsync    (scan_hsync),
    .vsync    (scan_vsync),
    .de       (scan_de),
    .frame_end(frame_end)
  );

  pixel_out u_pixel_out (
    .clk      (clk),
    .rst_n    (rst_n),
    .rdata    (rd_bus.rdata),
    .hsync    (scan_hsync),
    .vsync    (scan_vsync),
    .de       (scan_de),
    .vga_red  (vga_red),
    .vga_green(vga_green),
    .vga_blue (vga_blue),
    .vga_hsync(vga_hsync),
    .vga_vsync(vga_vsync),
    .vga_de   (vga_de)
  );

endmodule

`default_nettype wire

//--- dv/frame_buffer_tb.sv
`timescale 1ns/1ps
`default_nettype none

module frame_buffer_tb import frame_pkg::*; ();

  logic               clk;
  logic               rst_n;
  logic               wr_en;
  logic [pixel_w-1:0] wr_pixel;
  logic               wr_busy;
  logic               frame_swap;
  logic [3:0]         vga_red;
  logic [3:0]         vga_green;
  logic [3:0]         vga_blue;
  logic               vga_hsync;
  logic               vga_vsync;
  logic               vga_de;

  // host frames A, B and C
  logic [pixel_w-1:0] frames [3][frame_pixels];
  integer seed = 67737;
  int errors = 0;
  int test_errors = 0;
  int front_id = -1;
  int pend_id = -1;
  int shown [3];
  int line = 0;
  int col = 0;
  int de_cnt = 0;
  int hs_cnt = 0;
  int hs_run = 0;
  int vs_cnt = 0;
  logic swap_d = 1'b0;
  bit timed_out = 1'b0;

  frame_buffer_top u_frame_buffer_top (
    .clk       (clk),
    .rst_n     (rst_n),
    .wr_en     (wr_en),
    .wr_pixel  (wr_pixel),
    .wr_busy   (wr_busy),
    .frame_swap(frame_swap),
    .vga_red   (vga_red),
    .vga_green (vga_green),
    .vga_blue  (vga_blue),
    .vga_hsync (vga_hsync),
    .vga_vsync (vga_vsync),
    .vga_de    (vga_de)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // visible pixel at raster position, row major in the host frame
  function automatic logic [pixel_w-1:0] expected_pixel(int id, int y, int x);
    return frames[id][y * h_active + x];
  endfunction

  task automatic check_value(string name, int got, int exp);
    assert (got == exp) else begin
      errors++;
      $display("[ERROR] %s: got %h expected %h", name, got, exp);
    end
  endtask

  // remaining waits fall through once one has expired
  task automatic report_timeout(string why);
    $display("%s", why);
    errors++;
    timed_out = 1'b1;
  endtask

  task automatic end_test(string name);
    $display("test %-14s %s, %0d errors", name,
             (errors == test_errors) ? "ok" : "FAILED", errors - test_errors);
    test_errors = errors;
  endtask

  // one pixel per accepted strobe, random gaps in between
  task automatic write_frame(int id);
    int i = 0;
    int t = 0;
    while (i < frame_pixels && !timed_out) begin
      @(negedge clk);
      t++;
      if (t > 1000) begin
        report_timeout("timeout while streaming a frame into the writer");
      end else if ($random(seed) % 4 == 0) begin
        wr_en = 1'b0;
      end else begin
        wr_en    = 1'b1;
        wr_pixel = frames[id][i];
        i++;
      end
    end
    @(negedge clk);
    wr_en   = 1'b0;
    pend_id = id;
    check_value("wr_busy", wr_busy, 1);
  endtask

  // optionally keep offering junk pixels until the swap releases the writer
  task automatic wait_swap(bit offer_junk);
    int t = 0;
    while (wr_busy && !timed_out) begin
      wr_en    = offer_junk;
      wr_pixel = $random(seed);
      @(negedge clk);
      t++;
      if (t > 1000) report_timeout($sformatf("timeout waiting for the bank swap, switch in %s",
                                             u_frame_buffer_top.u_bank_switch.state.name()));
    end
    wr_en = 1'b0;
    check_value("frame_swap", frame_swap, 1);
  endtask

  task automatic wait_shown(int id, int n);
    int t = 0;
    int target = shown[id] + n;
    while (shown[id] < target && !timed_out) begin
      @(negedge clk);
      t++;
      if (t > 600 * n) report_timeout("timeout waiting for a complete displayed frame");
    end
  endtask

  // output monitor and pixel checker
  always @(posedge clk) begin
    if (!rst_n) begin
      line   = 0;
      col    = 0;
      hs_run = 0;
      swap_d = 1'b0;
    end else begin
      assert (!(frame_swap && swap_d)) else begin
        errors++;
        $display("frame_swap stayed high for more than one cycle");
      end
      swap_d = frame_swap;
      if (frame_swap) front_id = pend_id;
      if (!vga_vsync) line = 0;
      // width of every hsync pulse
      if (!vga_hsync) begin
        hs_cnt++;
        hs_run++;
      end else if (hs_run != 0) begin
        check_value("vga_hsync pulse", hs_run, h_sync_end - h_sync_start);
        hs_run = 0;
      end
      if (!vga_vsync) vs_cnt++;
      if (vga_de) begin
        de_cnt++;
        if (front_id >= 0) begin
          assert ({vga_red, vga_green, vga_blue} == expected_pixel(front_id, line, col)) else begin
            errors++;
            $display("[ERROR] vga_rgb line %0d col %0d: got %h expected %h", line, col,
                     {vga_red, vga_green, vga_blue}, expected_pixel(front_id, line, col));
          end
        end
        col++;
      end else if (col != 0) begin
        check_value("vga_de per line", col, h_active);
        if (line == v_active - 1 && front_id >= 0) shown[front_id]++;
        line++;
        col = 0;
      end
    end
  end

  initial begin
    int de0;
    int hs0;
    int vs0;
    rst_n    = 1'b0;
    wr_en    = 1'b0;
    wr_pixel = '0;
    for (int f = 0; f < 3; f++) begin
      for (int p = 0; p < frame_pixels; p++) begin
        frames[f][p] = $random(seed);
      end
    end
    repeat (8) @(posedge clk);
    @(negedge clk);
    check_value("wr_busy", wr_busy, 0);
    check_value("frame_swap", frame_swap, 0);
    check_value("vga_de", vga_de, 0);
    check_value("vga_hsync", vga_hsync, 1);
    check_value("vga_vsync", vga_vsync, 1);
    check_value("vga_rgb", {vga_red, vga_green, vga_blue}, 0);
    end_test("reset");
    rst_n = 1'b1;

    // two whole frames of steady raster output
    repeat (20) @(negedge clk);
    de0 = de_cnt;
    hs0 = hs_cnt;
    vs0 = vs_cnt;
    repeat (2 * h_total * v_total) @(negedge clk);
    check_value("vga_de cycles", de_cnt - de0, 2 * frame_pixels);
    check_value("vga_hsync low cycles", hs_cnt - hs0, 2 * v_total * (h_sync_end - h_sync_start));
    check_value("vga_vsync low cycles", vs_cnt - vs0, 2 * h_total);
    end_test("raster_timing");

    write_frame(0);
    wait_swap(1'b0);
    wait_shown(0, 1);
    end_test("first_frame");

    // B goes to the back bank while A is on screen, junk offered while held
    write_frame(1);
    wait_swap(1'b1);
    wait_shown(1, 1);
    end_test("write_blocked");

    write_frame(2);
    wait_swap(1'b0);
    wait_shown(2, 1);
    check_value("frames of A shown", (shown[0] >= 2) ? 1 : 0, 1);
    for (int p = 0; p < frame_pixels; p++) begin
      check_value("bank1 word", u_frame_buffer_top.u_bank1.store[p], frames[2][p]);
    end
    end_test("double_buffer");

    $display("tests 5, frames shown %0d/%0d/%0d, errors %0d", shown[0], shown[1], shown[2],
             errors);
    if (errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- filelist.f
logic/frame_pkg.sv
logic/mem_if.sv
logic/frame_writer.sv
logic/bank_switch.sv
logic/frame_bank.sv
logic/raster_scan.sv
logic/pixel_out.sv
logic/frame_buffer_top.sv
dv/frame_buffer_tb.sv
